// File: Bender.yml
package:
  name: mem_subsys

sources:
  - source/soc_pkg.sv
  - source/xbar.sv
  - source/axi_sram.sv
  - source/uart_sink.sv
  - source/mem_subsys.sv
  - target: test
    files:
      - tb/mem_subsys_properties.sv
      - tb/mem_checker.sv
      - tb/tb_mem_subsys.sv

// File: files.f
source/soc_pkg.sv
source/xbar.sv
source/axi_sram.sv
source/uart_sink.sv
source/mem_subsys.sv
tb/mem_subsys_properties.sv
tb/mem_checker.sv
tb/tb_mem_subsys.sv

// File: source/axi_sram.sv
`timescale 1ns/1ps
module axi_sram (
	input  logic                clk,
	input  logic                reset,

	input  logic [31:0]         araddr,
	input  logic                arvalid,
	output logic                arready,

	output logic [31:0]         rdata,
	output soc_pkg::axi_resp_e  rresp,
	output logic                rvalid,
	input  logic                rready,

	input  logic [31:0]         awaddr,
	input  logic                awvalid,
	output logic                awready,

	input  logic [31:0]         wdata,
	input  logic [3:0]          wstrb,
	input  logic                wvalid,
	output logic                wready,

	output soc_pkg::axi_resp_e  bresp,
	output logic                bvalid,
	input  logic                bready
);
	import soc_pkg::*;

	logic [31:0]           mem [sram_words];
	slv_state_e            rd_state;
	slv_state_e            wr_state;
	logic [31:0]           rdata_q;
	axi_resp_e             rresp_q;
	axi_resp_e             bresp_q;
	logic                  rd_take;
	logic                  wr_take;
	logic [sram_idx_w-1:0] rd_idx;
	logic [sram_idx_w-1:0] wr_idx;

	assign rd_idx = araddr[sram_idx_w+1:2];
	assign wr_idx = awaddr[sram_idx_w+1:2];

	assign arready = (rd_state == slv_idle);
	assign rd_take = arvalid && arready;

	always_ff @(posedge clk) begin
		if (reset) begin
			rd_state <= slv_idle;
		end else if (rd_state == slv_idle) begin
			if (rd_take) begin
				rd_state <= slv_resp;
			end
		end else if (rready) begin
			rd_state <= slv_idle;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_take) begin
			rdata_q <= mem[rd_idx];
			rresp_q <= in_sram(araddr) ? resp_okay : resp_slverr; // reads outside the window alias.
		end
	end

	assign rvalid = (rd_state == slv_resp);
	assign rdata  = rdata_q;
	assign rresp  = rresp_q;

	// address and data are accepted together, so both readies follow the same state.
	assign awready = (wr_state == slv_idle);
	assign wready  = (wr_state == slv_idle);
	assign wr_take = awvalid && wvalid && awready;

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_state <= slv_idle;
		end else if (wr_state == slv_idle) begin
			if (wr_take) begin
				wr_state <= slv_resp;
			end
		end else if (bready) begin
			wr_state <= slv_idle;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_take) begin
			for (int i = 0; i < 4; i++) begin
				if (wstrb[i]) begin
					mem[wr_idx][8*i +: 8] <= wdata[8*i +: 8];
				end
			end
			bresp_q <= in_sram(awaddr) ? resp_okay : resp_slverr;
		end
	end

	assign bvalid = (wr_state == slv_resp);
	assign bresp  = bresp_q;

endmodule

// File: source/mem_subsys.sv
`timescale 1ns/1ps
module mem_subsys (
	input  logic                clk,
	input  logic                reset,

	input  logic [31:0]         ifu_araddr,
	input  logic                ifu_arvalid,
	output logic                ifu_arready,
	output logic [31:0]         ifu_rdata,
	output soc_pkg::axi_resp_e  ifu_rresp,
	output logic                ifu_rvalid,
	input  logic                ifu_rready,

	input  logic [31:0]         lsu_araddr,
	input  logic                lsu_arvalid,
	output logic                lsu_arready,
	output logic [31:0]         lsu_rdata,
	output soc_pkg::axi_resp_e  lsu_rresp,
	output logic                lsu_rvalid,
	input  logic                lsu_rready,
	input  logic [31:0]         lsu_awaddr,
	input  logic                lsu_awvalid,
	output logic                lsu_awready,
	input  logic [31:0]         lsu_wdata,
	input  logic [3:0]          lsu_wstrb,
	input  logic                lsu_wvalid,
	output logic                lsu_wready,
	output soc_pkg::axi_resp_e  lsu_bresp,
	output logic                lsu_bvalid,
	input  logic                lsu_bready,

	output logic [7:0]          tx_data,
	output logic                tx_valid
);
	import soc_pkg::*;

	logic [31:0] sram_araddr;
	logic [31:0] sram_rdata;
	logic [31:0] sram_awaddr;
	logic [31:0] sram_wdata;
	logic [3:0]  sram_wstrb;
	logic        sram_arvalid, sram_arready, sram_rvalid, sram_rready;
	logic        sram_awvalid, sram_awready, sram_wvalid, sram_wready;
	logic        sram_bvalid, sram_bready;
	axi_resp_e   sram_rresp;
	axi_resp_e   sram_bresp;

	logic [31:0] uart_awaddr;
	logic [31:0] uart_wdata;
	logic [3:0]  uart_wstrb;
	logic        uart_awvalid, uart_awready, uart_wvalid, uart_wready;
	logic        uart_bvalid, uart_bready;
	axi_resp_e   uart_bresp;

	// every crossbar port has a same-named signal in this scope.
	xbar u_xbar (.*);

	axi_sram u_sram (
		.clk     (clk),
		.reset   (reset),
		.araddr  (sram_araddr),
		.arvalid (sram_arvalid),
		.arready (sram_arready),
		.rdata   (sram_rdata),
		.rresp   (sram_rresp),
		.rvalid  (sram_rvalid),
		.rready  (sram_rready),
		.awaddr  (sram_awaddr),
		.awvalid (sram_awvalid),
		.awready (sram_awready),
		.wdata   (sram_wdata),
		.wstrb   (sram_wstrb),
		.wvalid  (sram_wvalid),
		.wready  (sram_wready),
		.bresp   (sram_bresp),
		.bvalid  (sram_bvalid),
		.bready  (sram_bready)
	);

	uart_sink u_uart (
		.clk      (clk),
		.reset    (reset),
		.awaddr   (uart_awaddr),
		.awvalid  (uart_awvalid),
		.awready  (uart_awready),
		.wdata    (uart_wdata),
		.wstrb    (uart_wstrb),
		.wvalid   (uart_wvalid),
		.wready   (uart_wready),
		.bresp    (uart_bresp),
		.bvalid   (uart_bvalid),
		.bready   (uart_bready),
		.tx_data  (tx_data),
		.tx_valid (tx_valid)
	);

endmodule

// File: source/soc_pkg.sv
package soc_pkg;

	// write window of the SRAM and the UART data register.
	localparam logic [31:0] sram_base = 32'h8000_0000;
	localparam logic [31:0] sram_last = 32'h87ff_ffff;
	localparam logic [31:0] uart_addr = 32'ha000_03f8;

	localparam int sram_words = 1024;
	localparam int sram_idx_w = $clog2(sram_words); // word index is address bits 11:2.

	typedef enum logic [1:0] {
		resp_okay   = 2'd0,
		resp_slverr = 2'd2,
		resp_decerr = 2'd3
	} axi_resp_e;

	typedef enum logic [1:0] {
		rd_idle,
		rd_ifu,
		rd_lsu
	} rd_owner_e;

	typedef enum logic [1:0] {
		slv_idle,
		slv_resp
	} slv_state_e;

	function automatic logic in_sram(logic [31:0] addr);
		in_sram = (addr >= sram_base) && (addr <= sram_last);
	endfunction

endpackage

// File: source/uart_sink.sv
`timescale 1ns/1ps
module uart_sink (
	input  logic                clk,
	input  logic                reset,

	input  logic [31:0]         awaddr,
	input  logic                awvalid,
	output logic                awready,

	input  logic [31:0]         wdata,
	input  logic [3:0]          wstrb,
	input  logic                wvalid,
	output logic                wready,

	output soc_pkg::axi_resp_e  bresp,
	output logic                bvalid,
	input  logic                bready,

	output logic [7:0]          tx_data,
	output logic                tx_valid
);
	import soc_pkg::*;

	slv_state_e state;
	logic       take;
	logic [7:0] tx_data_q;

	// awaddr carries no information here, the crossbar has already decoded it.
	assign awready = (state == slv_idle);
	assign wready  = (state == slv_idle);
	assign take    = awvalid && wvalid && awready;

	always_ff @(posedge clk) begin
		if (reset) begin
			state    <= slv_idle;
			tx_valid <= 1'b0;
		end else begin
			tx_valid <= take && wstrb[0]; // one-cycle strobe per accepted byte.
			if (state == slv_idle) begin
				if (take) begin
					state <= slv_resp;
				end
			end else if (bready) begin
				state <= slv_idle;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			tx_data_q <= wdata[7:0];
		end
	end

	assign tx_data = tx_data_q;
	assign bvalid  = (state == slv_resp);
	assign bresp   = resp_okay;

endmodule

// File: source/xbar.sv
`timescale 1ns/1ps
module xbar (
	input  logic                clk,
	input  logic                reset,

	input  logic [31:0]         ifu_araddr,
	input  logic                ifu_arvalid,
	output logic                ifu_arready,
	output logic [31:0]         ifu_rdata,
	output soc_pkg::axi_resp_e  ifu_rresp,
	output logic                ifu_rvalid,
	input  logic                ifu_rready,

	input  logic [31:0]         lsu_araddr,
	input  logic                lsu_arvalid,
	output logic                lsu_arready,
	output logic [31:0]         lsu_rdata,
	output soc_pkg::axi_resp_e  lsu_rresp,
	output logic                lsu_rvalid,
	input  logic                lsu_rready,
	input  logic [31:0]         lsu_awaddr,
	input  logic                lsu_awvalid,
	output logic                lsu_awready,
	input  logic [31:0]         lsu_wdata,
	input  logic [3:0]          lsu_wstrb,
	input  logic                lsu_wvalid,
	output logic                lsu_wready,
	output soc_pkg::axi_resp_e  lsu_bresp,
	output logic                lsu_bvalid,
	input  logic                lsu_bready,

	output logic [31:0]         sram_araddr,
	output logic                sram_arvalid,
	input  logic                sram_arready,
	input  logic [31:0]         sram_rdata,
	input  soc_pkg::axi_resp_e  sram_rresp,
	input  logic                sram_rvalid,
	output logic                sram_rready,
	output logic [31:0]         sram_awaddr,
	output logic                sram_awvalid,
	input  logic                sram_awready,
	output logic [31:0]         sram_wdata,
	output logic [3:0]          sram_wstrb,
	output logic                sram_wvalid,
	input  logic                sram_wready,
	input  soc_pkg::axi_resp_e  sram_bresp,
	input  logic                sram_bvalid,
	output logic                sram_bready,

	output logic [31:0]         uart_awaddr,
	output logic                uart_awvalid,
	input  logic                uart_awready,
	output logic [31:0]         uart_wdata,
	output logic [3:0]          uart_wstrb,
	output logic                uart_wvalid,
	input  logic                uart_wready,
	input  soc_pkg::axi_resp_e  uart_bresp,
	input  logic                uart_bvalid,
	output logic                uart_bready
);
	import soc_pkg::*;

	rd_owner_e rd_state;
	rd_owner_e rd_next;
	logic      ifu_own;
	logic      lsu_own;
	logic      sram_sel;
	logic      uart_sel;
	logic      none_sel;
	logic      dec_take;
	logic      dec_bvalid;

	assign ifu_own = (rd_state == rd_ifu);
	assign lsu_own = (rd_state == rd_lsu);

	always_comb begin
		rd_next = rd_state;
		case (rd_state)
			rd_idle: begin
				if (ifu_arvalid) begin
					rd_next = rd_ifu; // fetch wins a tie.
				end else if (lsu_arvalid) begin
					rd_next = rd_lsu;
				end
			end
			rd_ifu: begin
				if (ifu_rvalid && ifu_rready) begin
					rd_next = rd_idle;
				end
			end
			rd_lsu: begin
				if (lsu_rvalid && lsu_rready) begin
					rd_next = rd_idle;
				end
			end
			default: rd_next = rd_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			rd_state <= rd_idle;
		end else begin
			rd_state <= rd_next;
		end
	end

	assign sram_araddr  = ifu_own ? ifu_araddr : (lsu_own ? lsu_araddr : '0);
	assign sram_arvalid = (ifu_own && ifu_arvalid) || (lsu_own && lsu_arvalid);
	assign ifu_arready  = ifu_own && sram_arready;
	assign lsu_arready  = lsu_own && sram_arready;

	assign ifu_rdata   = ifu_own ? sram_rdata : '0;
	assign lsu_rdata   = lsu_own ? sram_rdata : '0;
	assign ifu_rresp   = ifu_own ? sram_rresp : resp_okay;
	assign lsu_rresp   = lsu_own ? sram_rresp : resp_okay;
	assign ifu_rvalid  = ifu_own && sram_rvalid;
	assign lsu_rvalid  = lsu_own && sram_rvalid;
	assign sram_rready = (ifu_own && ifu_rready) || (lsu_own && lsu_rready);

	assign sram_sel = in_sram(lsu_awaddr);
	assign uart_sel = (lsu_awaddr == uart_addr);
	assign none_sel = !sram_sel && !uart_sel;

	assign sram_awaddr  = sram_sel ? lsu_awaddr : '0;
	assign sram_awvalid = sram_sel && lsu_awvalid;
	assign sram_wdata   = sram_sel ? lsu_wdata : '0;
	assign sram_wstrb   = sram_sel ? lsu_wstrb : '0;
	assign sram_wvalid  = sram_sel && lsu_wvalid;

	assign uart_awaddr  = uart_sel ? lsu_awaddr : '0;
	assign uart_awvalid = uart_sel && lsu_awvalid;
	assign uart_wdata   = uart_sel ? lsu_wdata : '0;
	assign uart_wstrb   = uart_sel ? lsu_wstrb : '0;
	assign uart_wvalid  = uart_sel && lsu_wvalid;

	// unmapped writes are taken here only when address and data are both present.
	assign dec_take = none_sel && lsu_awvalid && lsu_wvalid && !dec_bvalid;

	assign lsu_awready = (sram_sel && sram_awready) || (uart_sel && uart_awready) || dec_take;
	assign lsu_wready  = (sram_sel && sram_wready) || (uart_sel && uart_wready) || dec_take;

	always_ff @(posedge clk) begin
		if (reset) begin
			dec_bvalid <= 1'b0;
		end else if (dec_take) begin
			dec_bvalid <= 1'b1;
		end else if (dec_bvalid && lsu_bready) begin
			dec_bvalid <= 1'b0;
		end
	end

	// with one write in flight only the addressed responder can hold bvalid.
	assign lsu_bvalid  = sram_bvalid || uart_bvalid || dec_bvalid;
	assign sram_bready = sram_bvalid && lsu_bready;
	assign uart_bready = uart_bvalid && lsu_bready;

	always_comb begin
		if (dec_bvalid) begin
			lsu_bresp = resp_decerr;
		end else if (uart_bvalid) begin
			lsu_bresp = uart_bresp;
		end else begin
			lsu_bresp = sram_bresp;
		end
	end

endmodule

// File: tb/mem_cases.txt
// kind addr data strb exp_data exp_resp, one case per line, all hex.
// kind 1 fetch read, 2 lsu read, 3 lsu write, 4 both read the same word, 0 ends the list.
3 80000010 11223344 f 00000000 0
3 80000010 aabbccdd 5 00000000 0
2 80000010 00000000 0 11bb33dd 0
3 80000020 cafef00d f 00000000 0
1 80000020 00000000 0 cafef00d 0
4 80000010 00000000 0 11bb33dd 0
3 a00003f8 00000041 1 00000000 0
3 a00003f8 0000005a e 00000000 0
3 90000010 deadbeef f 00000000 3
2 80000010 00000000 0 11bb33dd 0
3 87fffffc 01234567 f 00000000 0
1 87fffffc 00000000 0 01234567 0
3 80000020 00990000 4 00000000 0
1 80000020 00000000 0 ca99f00d 0
4 87fffffc 00000000 0 01234567 0
2 80000020 00000000 0 ca99f00d 0
0 00000000 00000000 0 00000000 0

// File: tb/mem_checker.sv
`timescale 1ns/1ps
module mem_checker (
	input  logic                clk,
	input  logic                reset,
	input  logic                ifu_rvalid,
	input  logic                ifu_rready,
	input  logic [31:0]         ifu_rdata,
	input  soc_pkg::axi_resp_e  ifu_rresp,
	input  logic                lsu_rvalid,
	input  logic                lsu_rready,
	input  logic [31:0]         lsu_rdata,
	input  soc_pkg::axi_resp_e  lsu_rresp,
	input  logic                lsu_bvalid,
	input  logic                lsu_bready,
	input  soc_pkg::axi_resp_e  lsu_bresp,
	input  logic                tx_valid,
	input  logic [7:0]          tx_data
);
	import soc_pkg::*;

	int          test_no, kind;
	logic [31:0] exp_data;
	axi_resp_e   exp_resp;
	bit          exp_tx;
	logic [7:0]  exp_byte;
	bit          active;
	int          ifu_seen, lsu_seen, b_seen, tx_seen, test_errs;
	int          passes, fails, stray;

	function automatic string kind_name(input int k);
		case (k)
			1: kind_name = "fetch read";
			2: kind_name = "lsu read";
			3: kind_name = "lsu write";
			default: kind_name = "both read";
		endcase
	endfunction

	task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] got);
		if (exp !== got) begin
			$display("ERROR test %0d: %s expected %h, got %h", test_no, name, exp, got);
			test_errs++;
		end
	endtask

	task automatic count_check(input string what, input int seen, input int want);
		if (seen != want) begin
			$display("test %0d: saw %0d %s, expected %0d", test_no, seen, what, want);
			test_errs++;
		end
	endtask

	// a transfer seen here completes on the next rising edge.
	always @(negedge clk) begin
		if (!reset && !active && (ifu_rvalid || lsu_rvalid || lsu_bvalid || tx_valid)) begin
			$display("unexpected response or transmit strobe outside any test");
			stray++;
		end else if (!reset && active) begin
			if (ifu_rvalid && ifu_rready) begin
				ifu_seen++;
				compare("ifu_rdata", exp_data, ifu_rdata);
				compare("ifu_rresp", exp_resp, ifu_rresp);
			end
			if (lsu_rvalid && lsu_rready) begin
				lsu_seen++;
				if (kind == 4 && ifu_seen == 0) begin
					$display("test %0d: lsu read finished before the fetch read", test_no);
					test_errs++;
				end
				compare("lsu_rdata", exp_data, lsu_rdata);
				compare("lsu_rresp", exp_resp, lsu_rresp);
			end
			if (lsu_bvalid && lsu_bready) begin
				b_seen++;
				compare("lsu_bresp", exp_resp, lsu_bresp);
			end
			if (tx_valid) begin
				tx_seen++;
				compare("tx_data", exp_byte, tx_data);
			end
		end
	end

	task automatic begin_test(input int num, input int k, input logic [31:0] data,
			input logic [1:0] resp, input bit tx, input logic [7:0] tx_byte);
		test_no   = num;
		kind      = k;
		exp_data  = data;
		exp_resp  = axi_resp_e'(resp);
		exp_tx    = tx;
		exp_byte  = tx_byte;
		ifu_seen  = 0;
		lsu_seen  = 0;
		b_seen    = 0;
		tx_seen   = 0;
		test_errs = 0;
		active    = 1'b1;
	endtask

	task automatic end_test(input bit timed_out);
		count_check("fetch read responses", ifu_seen, (kind == 1 || kind == 4) ? 1 : 0);
		count_check("lsu read responses", lsu_seen, (kind == 2 || kind == 4) ? 1 : 0);
		count_check("write responses", b_seen, (kind == 3) ? 1 : 0);
		count_check("transmit strobes", tx_seen, exp_tx ? 1 : 0);
		if (timed_out) begin
			test_errs++;
		end
		if (test_errs == 0) begin
			$display("test %0d %s: pass", test_no, kind_name(kind));
			passes++;
		end else begin
			$display("test %0d %s: fail with %0d errors", test_no, kind_name(kind), test_errs);
			fails++;
		end
		active = 1'b0;
	endtask

	task automatic close_report(output int n_fail);
		$display("tests %0d, passed %0d, failed %0d, stray events %0d",
			passes + fails, passes, fails, stray);
		n_fail = fails + stray;
	endtask

endmodule

// File: tb/mem_subsys_properties.sv
`timescale 1ns/1ps
module mem_subsys_properties (
	input  logic                clk,
	input  logic                reset,
	input  logic                ifu_rvalid,
	input  logic                ifu_rready,
	input  logic [31:0]         ifu_rdata,
	input  logic                lsu_rvalid,
	input  logic                lsu_rready,
	input  logic [31:0]         lsu_rdata,
	input  soc_pkg::rd_owner_e  rd_state
);
	import soc_pkg::*;

	int fail_count;

	// the single sram read port serves one master at a time.
	one_owner: assert property (@(posedge clk) disable iff (reset)
		!(ifu_rvalid && lsu_rvalid))
		else begin
			$error("fetch and lsu read data valid in the same cycle");
			fail_count++;
		end

	ifu_hold: assert property (@(posedge clk) disable iff (reset)
		ifu_rvalid && !ifu_rready |=> ifu_rvalid && $stable(ifu_rdata))
		else begin
			$error("fetch read data changed while stalled");
			fail_count++;
		end

	lsu_hold: assert property (@(posedge clk) disable iff (reset)
		lsu_rvalid && !lsu_rready |=> lsu_rvalid && $stable(lsu_rdata))
		else begin
			$error("lsu read data changed while stalled");
			fail_count++;
		end

	reset_idle: assert property (@(posedge clk) reset |=> rd_state == rd_idle)
		else begin
			$error("read arbiter not idle after reset");
			fail_count++;
		end

endmodule

// File: tb/tb_mem_subsys.sv
`timescale 1ns/1ps
module tb_mem_subsys;
	import soc_pkg::*;

	localparam int max_cases = 32;
	localparam int max_wait  = 20; // cycles any single handshake may take.

	logic        clk;
	logic        reset;
	logic [31:0] ifu_araddr, ifu_rdata;
	logic        ifu_arvalid, ifu_arready, ifu_rvalid, ifu_rready;
	axi_resp_e   ifu_rresp;
	logic [31:0] lsu_araddr, lsu_rdata, lsu_awaddr, lsu_wdata;
	logic [3:0]  lsu_wstrb;
	logic        lsu_arvalid, lsu_arready, lsu_rvalid, lsu_rready;
	logic        lsu_awvalid, lsu_awready, lsu_wvalid, lsu_wready;
	logic        lsu_bvalid, lsu_bready;
	axi_resp_e   lsu_rresp;
	axi_resp_e   lsu_bresp;
	logic [7:0]  tx_data;
	logic        tx_valid;

	logic [31:0] case_words [max_cases*6]; // six words per case line.
	integer      seed;
	int          timeouts;
	int          n_fail;

	mem_subsys DUT (.*);

	mem_checker chk (.*);

	bind xbar mem_subsys_properties props (
		.clk        (clk),
		.reset      (reset),
		.ifu_rvalid (ifu_rvalid),
		.ifu_rready (ifu_rready),
		.ifu_rdata  (ifu_rdata),
		.lsu_rvalid (lsu_rvalid),
		.lsu_rready (lsu_rready),
		.lsu_rdata  (lsu_rdata),
		.rd_state   (rd_state)
	);

	always #50 clk = ~clk;

	// channel 0 is ifu ar, 1 ifu r, 2 lsu ar, 3 lsu r, 4 lsu aw and w, 5 lsu b.
	function automatic bit xfer_now(input int ch);
		case (ch)
			0: xfer_now = ifu_arvalid && ifu_arready;
			1: xfer_now = ifu_rvalid && ifu_rready;
			2: xfer_now = lsu_arvalid && lsu_arready;
			3: xfer_now = lsu_rvalid && lsu_rready;
			4: xfer_now = lsu_awvalid && lsu_awready && lsu_wvalid && lsu_wready;
			default: xfer_now = lsu_bvalid && lsu_bready;
		endcase
	endfunction

	// looks at the handshake mid-cycle and returns just after the edge that completes it.
	task automatic wait_xfer(input int ch, input string what);
		int n;
		bit hit;
		hit = 1'b0;
		n = 0;
		while (!hit && n < max_wait) begin
			@(negedge clk);
			hit = xfer_now(ch);
			n++;
		end
		@(posedge clk);
		#1;
		if (!hit) begin
			$display("timeout: no %s transfer within %0d cycles", what, max_wait);
			timeouts++;
		end
	endtask

	task automatic do_read(input bit lsu, input logic [31:0] addr, input int hold);
		if (lsu) begin
			lsu_araddr  = addr;
			lsu_arvalid = 1'b1;
		end else begin
			ifu_araddr  = addr;
			ifu_arvalid = 1'b1;
		end
		wait_xfer(lsu ? 2 : 0, lsu ? "lsu read address" : "fetch read address");
		if (lsu)
			lsu_arvalid = 1'b0;
		else
			ifu_arvalid = 1'b0;
		repeat (hold) begin // rready stays low for a while to stall the data.
			@(posedge clk);
			#1;
		end
		if (lsu)
			lsu_rready = 1'b1;
		else
			ifu_rready = 1'b1;
		wait_xfer(lsu ? 3 : 1, lsu ? "lsu read data" : "fetch read data");
		if (lsu)
			lsu_rready = 1'b0;
		else
			ifu_rready = 1'b0;
	endtask

	task automatic do_write(input logic [31:0] addr, input logic [31:0] data,
			input logic [3:0] strb);
		lsu_awaddr  = addr;
		lsu_wdata   = data;
		lsu_wstrb   = strb;
		lsu_awvalid = 1'b1;
		lsu_wvalid  = 1'b1;
		lsu_bready  = 1'b1;
		wait_xfer(4, "lsu write address and data");
		lsu_awvalid = 1'b0;
		lsu_wvalid  = 1'b0;
		wait_xfer(5, "lsu write response");
		lsu_bready = 1'b0;
	endtask

	initial begin
		int idx;
		int t0;
		int d0;
		int d1;
		logic [31:0] kind, addr, data, strb, exp_data, exp_resp;
		bit exp_tx;
		clk = 1'b0;
		reset = 1'b1;
		ifu_araddr = '0;
		ifu_arvalid = 1'b0;
		ifu_rready = 1'b0;
		lsu_araddr = '0;
		lsu_arvalid = 1'b0;
		lsu_rready = 1'b0;
		lsu_awaddr = '0;
		lsu_awvalid = 1'b0;
		lsu_wdata = '0;
		lsu_wstrb = '0;
		lsu_wvalid = 1'b0;
		lsu_bready = 1'b0;
		seed = 13066;
		timeouts = 0;
		$readmemh("tb/mem_cases.txt", case_words);
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b0;
		idx = 0;
		while (idx < max_cases && case_words[6*idx] !== 32'h0 && !$isunknown(case_words[6*idx])) begin
			kind     = case_words[6*idx];
			addr     = case_words[6*idx+1];
			data     = case_words[6*idx+2];
			strb     = case_words[6*idx+3];
			exp_data = case_words[6*idx+4];
			exp_resp = case_words[6*idx+5];
			exp_tx   = (kind == 3) && (addr == uart_addr) && strb[0]; // only byte lane 0 is sent.
			t0 = timeouts;
			chk.begin_test(idx + 1, kind, exp_data, exp_resp[1:0], exp_tx, data[7:0]);
			case (kind)
				1: do_read(1'b0, addr, {$random(seed)} % 4);
				2: do_read(1'b1, addr, {$random(seed)} % 4);
				3: do_write(addr, data, strb[3:0]);
				default: begin
					d0 = {$random(seed)} % 4;
					d1 = {$random(seed)} % 4;
					fork
						do_read(1'b0, addr, d0);
						do_read(1'b1, addr, d1);
					join
				end
			endcase
			chk.end_test(timeouts != t0);
			repeat (2) begin // quiet cycles where any late response counts as stray.
				@(posedge clk);
				#1;
			end
			idx++;
		end
		chk.close_report(n_fail);
		if (n_fail == 0 && timeouts == 0 && DUT.u_xbar.props.fail_count == 0 && idx > 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule
